//--- files.f
design/symb_rate_pkg.sv
design/symb_rate_regs_pkg.sv
design/stream_skid_buffer.sv
design/symb_rate_interp.sv
design/symb_rate_regs.sv
design/symb_rate_divider_top.sv
sim/tb_symb_rate_divider.sv

//--- Bender.yml
package:
  name: symb_rate_divider

dependencies: {}

sources:
  # Packages first, then leaf modules, then the top level
  - design/symb_rate_pkg.sv
  - design/symb_rate_regs_pkg.sv
  - design/stream_skid_buffer.sv
  - design/symb_rate_interp.sv
  - design/symb_rate_regs.sv
  - design/symb_rate_divider_top.sv

  - target: simulation
    files:
      - sim/tb_symb_rate_divider.sv

//--- sim/tb_symb_rate_divider.sv
/* Symbol rate divider testbench */
module tb_symb_rate_divider
    import symb_rate_pkg::*;
    import symb_rate_regs_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED           = 32'hdc73_b5f2;
    localparam int          BUS_TIMEOUT    = 16;
    localparam int          STREAM_TIMEOUT = 400;
    localparam int          DRAIN_TIMEOUT  = 4000;
    localparam int          NO_WINDOW      = 1 << 30;

    logic                   clk_ifc_avmm;
    logic                   rst;
    logic [AVMM_ADDR_W-1:0] avmm_address;
    logic                   avmm_read;
    logic                   avmm_write;
    logic [AVMM_DATA_W-1:0] avmm_writedata;
    logic [AVMM_BE_W-1:0]   avmm_byteenable;
    logic                   avmm_waitrequest;
    logic [AVMM_DATA_W-1:0] avmm_readdata;
    logic                   avmm_readdatavalid;
    logic                   avmm_writeresponsevalid;
    logic [1:0]             avmm_response;
    logic                   s_valid;
    iq_sample_t             s_data;
    logic                   s_ready_o;
    logic                   m_valid_o;
    iq_sample_t             m_data_o;
    logic                   m_ready_i;

    string       test_name;
    logic [31:0] stim_rng;
    logic [31:0] ready_rng;
    bit          ready_random;
    iq_sample_t  model_prev;
    iq_sample_t  sent_q[$];
    iq_sample_t  rx_q[$];

    symb_rate_divider_top #(
        .MODULE_ID             (16'h5a17),
        .DEFAULT_SYMB_RATE_SEL (RATE_FULL)
    ) u_symb_rate_divider_top (
        .clk_ifc_avmm              (clk_ifc_avmm),
        .rst_i                     (rst),
        .avmm_address_i            (avmm_address),
        .avmm_read_i               (avmm_read),
        .avmm_write_i              (avmm_write),
        .avmm_writedata_i          (avmm_writedata),
        .avmm_byteenable_i         (avmm_byteenable),
        .avmm_waitrequest_o        (avmm_waitrequest),
        .avmm_readdata_o           (avmm_readdata),
        .avmm_readdatavalid_o      (avmm_readdatavalid),
        .avmm_writeresponsevalid_o (avmm_writeresponsevalid),
        .avmm_response_o           (avmm_response),
        .s_valid_i                 (s_valid),
        .s_data_i                  (s_data),
        .s_ready_o                 (s_ready_o),
        .m_valid_o                 (m_valid_o),
        .m_data_o                  (m_data_o),
        .m_ready_i                 (m_ready_i)
    );

    initial begin
        clk_ifc_avmm = 1'b0;
        forever #20 clk_ifc_avmm = ~clk_ifc_avmm;
    end

    //////////////////////////////////////////////////
    // Failure reporting

    task automatic end_with_failure();
        $display("*** FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic abort_run(input string what);
        $display("test %s: %s", test_name, what);
        end_with_failure();
    endtask

    task automatic report_mismatch(input logic [31:0] expected, input logic [31:0] actual);
        $display("mismatch in test %s: expected %h, actual %h", test_name, expected, actual);
        end_with_failure();
    endtask

    //////////////////////////////////////////////////
    // Reference model

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Floor of prev + (cur - prev) * k / n
    function automatic logic signed [15:0] lerp(input int p, input int c, input int n, input int k);
        int num;
        int quo;
        num = (c - p) * k;
        quo = num / n;
        if (num % n != 0 && num < 0) begin
            quo = quo - 1;
        end
        return 16'(p + quo);
    endfunction

    function automatic iq_sample_t expect_sample(input iq_sample_t prev, input iq_sample_t cur,
                                                 input int n, input int k);
        iq_sample_t s;
        s.i = lerp(prev.i, cur.i, n, k);
        s.q = lerp(prev.q, cur.q, n, k);
        return s;
    endfunction

    // Kind 1 opens with full-scale swings
    // Kind 2 alternates the sign of I with a large step
    function automatic iq_sample_t make_symbol(input int kind, input int idx, input logic [31:0] r);
        iq_sample_t s;
        s = iq_sample_t'(r);
        if (kind == 1 && idx < 4) begin
            s.i = idx[0] ? 16'sh8000 : 16'sh7fff;
            s.q = idx[0] ? 16'sh7fff : 16'sh8000;
        end else if (kind == 2) begin
            s.i = {~idx[0], idx[0], r[13:0]};
        end
        return s;
    endfunction

    //////////////////////////////////////////////////
    // Bus and stream tasks

    task automatic bus_access(input bit is_write, input int word, input logic [31:0] wdata,
                              input logic [3:0] be, output logic [31:0] rdata,
                              output logic [1:0] resp);
        int waited;
        avmm_address    = AVMM_ADDR_W'(word << WORD_ADDR_LSB);
        avmm_writedata  = wdata;
        avmm_byteenable = be;
        avmm_write      = is_write;
        avmm_read       = !is_write;
        waited = 0;
        while (avmm_waitrequest) begin
            @(negedge clk_ifc_avmm);
            waited++;
            if (waited > BUS_TIMEOUT) begin
                abort_run("timeout waiting for waitrequest to drop");
            end
        end
        assert (!avmm_readdatavalid && !avmm_writeresponsevalid)
            else abort_run("response seen before the command was accepted");
        // Accepted on the rising edge just passed
        @(negedge clk_ifc_avmm);
        avmm_write = 1'b0;
        avmm_read  = 1'b0;
        assert (avmm_writeresponsevalid == is_write && avmm_readdatavalid == !is_write)
            else abort_run("response not exactly one cycle after acceptance");
        rdata = avmm_readdata;
        resp  = avmm_response;
        @(negedge clk_ifc_avmm);
        assert (!avmm_readdatavalid && !avmm_writeresponsevalid)
            else abort_run("response valid held longer than one cycle");
    endtask

    task automatic expect_read(input int word, input logic [31:0] exp_data,
                               input logic [1:0] exp_resp);
        logic [31:0] data;
        logic [1:0]  resp;
        bus_access(1'b0, word, '0, '0, data, resp);
        assert (resp == exp_resp) else report_mismatch(exp_resp, resp);
        assert (data == exp_data) else report_mismatch(exp_data, data);
    endtask

    task automatic expect_write(input int word, input logic [31:0] data, input logic [3:0] be,
                                input logic [1:0] exp_resp);
        logic [31:0] unused;
        logic [1:0]  resp;
        bus_access(1'b1, word, data, be, unused, resp);
        assert (resp == exp_resp) else report_mismatch(exp_resp, resp);
    endtask

    task automatic send_symbols(input int n, input int kind);
        int waited;
        for (int idx = 0; idx < n; idx++) begin
            stim_rng = xorshift32(stim_rng);
            s_data   = make_symbol(kind, idx, stim_rng);
            s_valid  = 1'b1;
            waited   = 0;
            while (!s_ready_o) begin
                @(negedge clk_ifc_avmm);
                waited++;
                if (waited > STREAM_TIMEOUT) begin
                    abort_run("timeout waiting for s_ready_o");
                end
            end
            sent_q.push_back(s_data);
            @(negedge clk_ifc_avmm);
        end
        s_valid = 1'b0;
    endtask

    // Idle output for several cycles means the pipeline is empty
    task automatic wait_drained();
        int idle;
        int waited;
        idle   = 0;
        waited = 0;
        while (idle < 8) begin
            @(negedge clk_ifc_avmm);
            waited++;
            idle = m_valid_o ? 0 : idle + 1;
            if (waited > DRAIN_TIMEOUT) begin
                abort_run("timeout waiting for the output stream to drain");
            end
        end
    endtask

    // Symbols from win_lo to win_hi keep the old rate until the first one switches
    task automatic check_stream(input int old_div, input int new_div,
                                input int win_lo, input int win_hi);
        iq_sample_t prev;
        iq_sample_t cur;
        iq_sample_t exp_s;
        int         n;
        int         pos;
        bit         switched;
        prev     = model_prev;
        pos      = 0;
        switched = 1'b0;
        foreach (sent_q[s]) begin
            cur = sent_q[s];
            if (s < win_lo) begin
                n = old_div;
            end else if (s > win_hi || switched) begin
                n = new_div;
            end else begin
                assert (pos < rx_q.size()) else abort_run("output ended inside rate change");
                switched = (rx_q[pos] == expect_sample(prev, cur, new_div, 1));
                n = switched ? new_div : old_div;
            end
            for (int k = 1; k <= n; k++) begin
                assert (pos < rx_q.size()) else abort_run("output sample missing");
                exp_s = expect_sample(prev, cur, n, k);
                assert (rx_q[pos] == exp_s) else report_mismatch(exp_s, rx_q[pos]);
                pos++;
            end
            prev = cur;
        end
        assert (pos == rx_q.size()) else abort_run("more output samples than symbols allow");
        model_prev = prev;
        sent_q.delete();
        rx_q.delete();
    endtask

    //////////////////////////////////////////////////
    // Output sink and monitor

    always @(negedge clk_ifc_avmm) begin
        if (ready_random) begin
            ready_rng = xorshift32(ready_rng);
            m_ready_i = ready_rng[7];
        end else begin
            m_ready_i = 1'b1;
        end
        // Transfer happens on the coming rising edge
        if (m_valid_o && m_ready_i) begin
            rx_q.push_back(m_data_o);
        end
    end

    property hold_while_stalled;
        @(posedge clk_ifc_avmm) disable iff (rst)
            (m_valid_o && !m_ready_i) |=> (m_valid_o && $stable(m_data_o));
    endproperty

    assert property (hold_while_stalled)
        else abort_run("output sample dropped or changed while stalled");

    //////////////////////////////////////////////////
    // Test sequence

    initial begin
        int w0;
        int w1;
        rst             = 1'b1;
        avmm_address    = '0;
        avmm_read       = 1'b0;
        avmm_write      = 1'b0;
        avmm_writedata  = '0;
        avmm_byteenable = '0;
        s_valid         = 1'b0;
        s_data          = '0;
        m_ready_i       = 1'b1;
        ready_random    = 1'b0;
        stim_rng        = SEED;
        ready_rng       = {SEED[15:0], SEED[31:16]};
        model_prev      = '0;
        test_name       = "reset";
        repeat (2) @(posedge clk_ifc_avmm);
        @(negedge clk_ifc_avmm);
        assert (avmm_waitrequest) else abort_run("waitrequest low during reset");
        rst = 1'b0;
        @(negedge clk_ifc_avmm);
        assert (!m_valid_o && !avmm_readdatavalid && !avmm_writeresponsevalid)
            else abort_run("valid output high after reset");
        expect_read(ADDR_ID, {16'h5a17, 16'h0001}, RESP_OKAY);
        expect_read(ADDR_SYMB_RATE_SEL, 32'(RATE_FULL), RESP_OKAY);
        expect_read(ADDR_SYMB_RATE_DIV, 32'd1, RESP_OKAY);

        test_name = "register_access";
        expect_write(ADDR_SCRATCH, 32'h1122_3344, 4'hf, RESP_OKAY);
        expect_write(ADDR_SCRATCH, 32'haabb_ccdd, 4'b0101, RESP_OKAY);
        expect_read(ADDR_SCRATCH, 32'h11bb_33dd, RESP_OKAY);
        expect_write(ADDR_SYMB_RATE_DIV, 32'h0000_0006, 4'hf, RESP_OKAY);
        expect_read(ADDR_SYMB_RATE_DIV, 32'd1, RESP_OKAY);
        expect_read(NUM_REGS, 32'd0, RESP_SLAVE_ERROR);
        expect_write(NUM_REGS, 32'hffff_ffff, 4'hf, RESP_SLAVE_ERROR);

        test_name = "full_rate";
        send_symbols(20, 0);
        wait_drained();
        check_stream(1, 1, NO_WINDOW, NO_WINDOW);

        test_name = "half_rate";
        expect_write(ADDR_SYMB_RATE_SEL, 32'(RATE_HALF), 4'hf, RESP_OKAY);
        expect_read(ADDR_SYMB_RATE_DIV, 32'd2, RESP_OKAY);
        send_symbols(16, 1);
        wait_drained();
        check_stream(2, 2, NO_WINDOW, NO_WINDOW);

        test_name = "quarter_rate";
        expect_write(ADDR_SYMB_RATE_SEL, 32'(RATE_QUARTER), 4'hf, RESP_OKAY);
        expect_read(ADDR_SYMB_RATE_DIV, 32'd4, RESP_OKAY);
        send_symbols(16, 1);
        wait_drained();
        check_stream(4, 4, NO_WINDOW, NO_WINDOW);

        test_name    = "back_pressure";
        ready_random = 1'b1;
        send_symbols(24, 0);
        wait_drained();
        ready_random = 1'b0;
        check_stream(4, 4, NO_WINDOW, NO_WINDOW);

        test_name = "rate_change";
        w0 = 0;
        w1 = 0;
        fork
            send_symbols(24, 2);
            begin
                int waited;
                waited = 0;
                while (sent_q.size() < 8) begin
                    @(negedge clk_ifc_avmm);
                    waited++;
                    if (waited > STREAM_TIMEOUT) begin
                        abort_run("timeout waiting for symbols before the rate change");
                    end
                end
                w0 = sent_q.size();
                expect_write(ADDR_SYMB_RATE_SEL, 32'(RATE_HALF), 4'hf, RESP_OKAY);
                w1 = sent_q.size();
            end
        join
        wait_drained();
        check_stream(4, 2, w0 - 4, w1 + 2);
        expect_read(ADDR_SYMB_RATE_DIV, 32'd2, RESP_OKAY);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- design/symb_rate_divider_top.sv
/* TX symbol rate divider */
module symb_rate_divider_top
    import symb_rate_pkg::*;
    import symb_rate_regs_pkg::*;
#(
    parameter logic [15:0]    MODULE_ID             = 16'h0000,
    parameter symb_rate_sel_e DEFAULT_SYMB_RATE_SEL = RATE_FULL
) (
    input  logic                   clk_ifc_avmm,
    input  logic                   rst_i,

    // Avalon-MM control slave
    input  logic [AVMM_ADDR_W-1:0] avmm_address_i,
    input  logic                   avmm_read_i,
    input  logic                   avmm_write_i,
    input  logic [AVMM_DATA_W-1:0] avmm_writedata_i,
    input  logic [AVMM_BE_W-1:0]   avmm_byteenable_i,
    output logic                   avmm_waitrequest_o,
    output logic [AVMM_DATA_W-1:0] avmm_readdata_o,
    output logic                   avmm_readdatavalid_o,
    output logic                   avmm_writeresponsevalid_o,
    output logic [1:0]             avmm_response_o,

    // Symbol stream in
    input  logic                   s_valid_i,
    input  iq_sample_t             s_data_i,
    output logic                   s_ready_o,

    // Sample stream out
    output logic                   m_valid_o,
    output iq_sample_t             m_data_o,
    input  logic                   m_ready_i
);

    symb_rate_sel_e symb_rate_sel;

    logic           sym_valid;
    iq_sample_t     sym_data;
    logic           sym_ready;

    logic           smp_valid;
    iq_sample_t     smp_data;
    logic           smp_ready;

    symb_rate_regs #(
        .MODULE_ID             (MODULE_ID),
        .DEFAULT_SYMB_RATE_SEL (DEFAULT_SYMB_RATE_SEL)
    ) u_regs (
        .clk_ifc_avmm              (clk_ifc_avmm),
        .rst_i                     (rst_i),
        .avmm_address_i            (avmm_address_i),
        .avmm_read_i               (avmm_read_i),
        .avmm_write_i              (avmm_write_i),
        .avmm_writedata_i          (avmm_writedata_i),
        .avmm_byteenable_i         (avmm_byteenable_i),
        .avmm_waitrequest_o        (avmm_waitrequest_o),
        .avmm_readdata_o           (avmm_readdata_o),
        .avmm_readdatavalid_o      (avmm_readdatavalid_o),
        .avmm_writeresponsevalid_o (avmm_writeresponsevalid_o),
        .avmm_response_o           (avmm_response_o),
        .symb_rate_sel_o           (symb_rate_sel)
    );

    stream_skid_buffer #(
        .payload_t (iq_sample_t)
    ) u_in_skid (
        .clk_ifc_avmm (clk_ifc_avmm),
        .rst_i        (rst_i),
        .in_valid_i   (s_valid_i),
        .in_data_i    (s_data_i),
        .in_ready_o   (s_ready_o),
        .out_valid_o  (sym_valid),
        .out_data_o   (sym_data),
        .out_ready_i  (sym_ready)
    );

    symb_rate_interp u_interp (
        .clk_ifc_avmm    (clk_ifc_avmm),
        .rst_i           (rst_i),
        .symb_rate_sel_i (symb_rate_sel),
        .in_valid_i      (sym_valid),
        .in_data_i       (sym_data),
        .in_ready_o      (sym_ready),
        .out_valid_o     (smp_valid),
        .out_data_o      (smp_data),
        .out_ready_i     (smp_ready)
    );

    stream_skid_buffer #(
        .payload_t (iq_sample_t)
    ) u_out_skid (
        .clk_ifc_avmm (clk_ifc_avmm),
        .rst_i        (rst_i),
        .in_valid_i   (smp_valid),
        .in_data_i    (smp_data),
        .in_ready_o   (smp_ready),
        .out_valid_o  (m_valid_o),
        .out_data_o   (m_data_o),
        .out_ready_i  (m_ready_i)
    );

endmodule

//--- design/symb_rate_regs.sv
/* Symbol rate control registers */
module symb_rate_regs
    import symb_rate_pkg::*;
    import symb_rate_regs_pkg::*;
#(
    parameter logic [15:0]    MODULE_ID             = 16'h0000,
    parameter symb_rate_sel_e DEFAULT_SYMB_RATE_SEL = RATE_FULL
) (
    input  logic                   clk_ifc_avmm,
    input  logic                   rst_i,

    input  logic [AVMM_ADDR_W-1:0] avmm_address_i,
    input  logic                   avmm_read_i,
    input  logic                   avmm_write_i,
    input  logic [AVMM_DATA_W-1:0] avmm_writedata_i,
    input  logic [AVMM_BE_W-1:0]   avmm_byteenable_i,
    output logic                   avmm_waitrequest_o,
    output logic [AVMM_DATA_W-1:0] avmm_readdata_o,
    output logic                   avmm_readdatavalid_o,
    output logic                   avmm_writeresponsevalid_o,
    output logic [1:0]             avmm_response_o,

    output symb_rate_sel_e         symb_rate_sel_o
);

    localparam int WORD_ADDR_W = AVMM_ADDR_W - WORD_ADDR_LSB;

    // Apply byteenable to a register word
    function automatic logic [AVMM_DATA_W-1:0] byte_merge(
        input logic [AVMM_DATA_W-1:0] old_word,
        input logic [AVMM_DATA_W-1:0] new_word,
        input logic [AVMM_BE_W-1:0]   be
    );
        logic [AVMM_DATA_W-1:0] merged;
        merged = old_word;
        for (int b = 0; b < AVMM_BE_W; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    logic [WORD_ADDR_W-1:0] word_addr;
    logic                   addr_err;
    logic                   rd_accept;
    logic                   wr_accept;
    logic [AVMM_DATA_W-1:0] rd_word;

    logic                   waitrequest_q;
    logic                   readdatavalid_q;
    logic                   writeresponsevalid_q;
    logic [AVMM_DATA_W-1:0] readdata_q;
    logic [1:0]             response_q;
    logic [AVMM_DATA_W-1:0] scratch_q;
    symb_rate_sel_e         sel_q;

    //////////////////////////////////////////////////
    // Command decode

    assign word_addr = avmm_address_i[AVMM_ADDR_W-1:WORD_ADDR_LSB];
    assign addr_err  = word_addr >= NUM_REGS;
    assign rd_accept = avmm_read_i && !waitrequest_q;
    assign wr_accept = avmm_write_i && !waitrequest_q;

    // Read mux, zero for unmapped words
    always_comb begin
        case (word_addr)
            ADDR_ID:            rd_word = {MODULE_ID, MODULE_VERSION};
            ADDR_SCRATCH:       rd_word = scratch_q;
            ADDR_SYMB_RATE_SEL: rd_word = AVMM_DATA_W'(sel_q);
            ADDR_SYMB_RATE_DIV: rd_word = AVMM_DATA_W'(rate_divisor(sel_q));
            default:            rd_word = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Register state

    always_ff @(posedge clk_ifc_avmm) begin
        if (rst_i) begin
            waitrequest_q        <= 1'b1;
            readdatavalid_q      <= 1'b0;
            writeresponsevalid_q <= 1'b0;
            scratch_q            <= '0;
            sel_q                <= DEFAULT_SYMB_RATE_SEL;
        end else begin
            waitrequest_q        <= 1'b0;
            readdatavalid_q      <= rd_accept;
            writeresponsevalid_q <= wr_accept;
            // ID and DIV are read-only, writes there fall through
            if (wr_accept && !addr_err) begin
                case (word_addr)
                    ADDR_SCRATCH: begin
                        scratch_q <= byte_merge(scratch_q, avmm_writedata_i,
                                                avmm_byteenable_i);
                    end
                    ADDR_SYMB_RATE_SEL: begin
                        if (avmm_byteenable_i[0]) begin
                            sel_q <= symb_rate_sel_e'(avmm_writedata_i[1:0]);
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Response payload, one cycle after acceptance
    always_ff @(posedge clk_ifc_avmm) begin
        if (rd_accept || wr_accept) begin
            response_q <= addr_err ? RESP_SLAVE_ERROR : RESP_OKAY;
        end
        if (rd_accept) begin
            readdata_q <= rd_word;
        end
    end

    assign avmm_waitrequest_o        = waitrequest_q;
    assign avmm_readdata_o           = readdata_q;
    assign avmm_readdatavalid_o      = readdatavalid_q;
    assign avmm_writeresponsevalid_o = writeresponsevalid_q;
    assign avmm_response_o           = response_q;
    assign symb_rate_sel_o           = sel_q;

endmodule

//--- design/symb_rate_interp.sv
/* Interpolating rate expander */
module symb_rate_interp
    import symb_rate_pkg::*;
(
    input  logic           clk_ifc_avmm,
    input  logic           rst_i,

    input  symb_rate_sel_e symb_rate_sel_i,

    input  logic           in_valid_i,
    input  iq_sample_t     in_data_i,
    output logic           in_ready_o,

    output logic           out_valid_o,
    output iq_sample_t     out_data_o,
    input  logic           out_ready_i
);

    //////////////////////////////////////////////////
    // Helpers

    // log2 of the divisor, used as the divide shift
    function automatic logic [1:0] div_shift(input logic [2:0] div);
        case (div)
            3'd4: begin
                return 2'd2;
            end
            3'd2: begin
                return 2'd1;
            end
            default: begin
                return 2'd0;
            end
        endcase
    endfunction

    // prev + (cur - prev) * k / N, exact for k in 1..N
    function automatic logic signed [15:0] interp_comp(
        input logic signed [15:0] prev,
        input logic signed [15:0] cur,
        input logic [2:0]         k,
        input logic [1:0]         sh
    );
        logic signed [16:0] diff;
        logic signed [19:0] step;
        logic signed [19:0] sum;
        diff = 17'(cur) - 17'(prev);
        step = diff * $signed({1'b0, k});
        step = step >>> sh;
        sum  = step + 20'(prev);
        return sum[15:0];
    endfunction

    //////////////////////////////////////////////////
    // State

    logic       active_q;
    logic [2:0] div_q;
    logic [2:0] k_q;
    iq_sample_t cur_q;
    iq_sample_t prev_q;

    logic       out_xfer;
    logic       last_xfer;
    logic       accept;
    logic [1:0] sh;

    assign out_xfer  = active_q && out_ready_i;
    assign last_xfer = out_xfer && (k_q == div_q);

    // Next symbol is taken as the last sample of this one leaves
    assign in_ready_o = !active_q || last_xfer;
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk_ifc_avmm) begin
        if (rst_i) begin
            active_q <= 1'b0;
            div_q    <= 3'd1;
            k_q      <= 3'd1;
            prev_q   <= '0;
        end else begin
            if (last_xfer) begin
                prev_q <= cur_q;
            end
            if (accept) begin
                // Rate is latched per symbol
                active_q <= 1'b1;
                div_q    <= rate_divisor(symb_rate_sel_i);
                k_q      <= 3'd1;
            end else if (last_xfer) begin
                active_q <= 1'b0;
            end else if (out_xfer) begin
                k_q <= k_q + 3'd1;
            end
        end
    end

    // Symbol payload
    always_ff @(posedge clk_ifc_avmm) begin
        if (accept) begin
            cur_q <= in_data_i;
        end
    end

    //////////////////////////////////////////////////
    // Output sample

    assign sh = div_shift(div_q);

    always_comb begin
        out_data_o.i = interp_comp(prev_q.i, cur_q.i, k_q, sh);
        out_data_o.q = interp_comp(prev_q.q, cur_q.q, k_q, sh);
    end

    assign out_valid_o = active_q;

endmodule

//--- design/stream_skid_buffer.sv
/* Valid/ready skid buffer */
module stream_skid_buffer #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk_ifc_avmm,
    input  logic     rst_i,

    input  logic     in_valid_i,
    input  payload_t in_data_i,
    output logic     in_ready_o,

    output logic     out_valid_o,
    output payload_t out_data_o,
    input  logic     out_ready_i
);

    logic     ready_q;
    logic     out_valid_q;
    logic     skid_valid_q;
    payload_t main_q;
    payload_t skid_q;

    logic     in_xfer;
    logic     out_valid_d;
    logic     skid_valid_d;
    logic     load_from_in;
    logic     load_from_skid;
    logic     load_skid;

    assign in_xfer = in_valid_i && ready_q;

    // Next state of the two entries
    always_comb begin
        out_valid_d    = out_valid_q;
        skid_valid_d   = skid_valid_q;
        load_from_in   = 1'b0;
        load_from_skid = 1'b0;
        load_skid      = 1'b0;
        if (!out_valid_q || out_ready_i) begin
            // Main register free or draining this cycle
            if (skid_valid_q) begin
                out_valid_d    = 1'b1;
                skid_valid_d   = 1'b0;
                load_from_skid = 1'b1;
            end else begin
                out_valid_d  = in_xfer;
                load_from_in = in_xfer;
            end
        end else if (in_xfer) begin
            // Downstream stalled, park in skid entry
            skid_valid_d = 1'b1;
            load_skid    = 1'b1;
        end
    end

    always_ff @(posedge clk_ifc_avmm) begin
        if (rst_i) begin
            ready_q      <= 1'b0;
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else begin
            ready_q      <= !skid_valid_d;
            out_valid_q  <= out_valid_d;
            skid_valid_q <= skid_valid_d;
        end
    end

    always_ff @(posedge clk_ifc_avmm) begin
        if (load_from_skid) begin
            main_q <= skid_q;
        end else if (load_from_in) begin
            main_q <= in_data_i;
        end
        if (load_skid) begin
            skid_q <= in_data_i;
        end
    end

    assign in_ready_o  = ready_q;
    assign out_valid_o = out_valid_q;
    assign out_data_o  = main_q;

endmodule

//--- design/symb_rate_regs_pkg.sv
/* Symbol rate register map */
package symb_rate_regs_pkg;

    //////////////////////////////////////////////////
    // Bus geometry

    localparam int AVMM_ADDR_W   = 8;
    localparam int AVMM_DATA_W   = 32;
    localparam int AVMM_BE_W     = AVMM_DATA_W / 8;

    // Byte address bits below the word address
    localparam int WORD_ADDR_LSB = $clog2(AVMM_BE_W);

    //////////////////////////////////////////////////
    // Word addresses

    localparam int ADDR_ID            = 0;
    localparam int ADDR_SCRATCH       = 1;
    localparam int ADDR_SYMB_RATE_SEL = 2;
    localparam int ADDR_SYMB_RATE_DIV = 3;
    localparam int NUM_REGS           = 4;

    //////////////////////////////////////////////////
    // Avalon-MM response codes

    localparam logic [1:0] RESP_OKAY        = 2'b00;
    localparam logic [1:0] RESP_SLAVE_ERROR = 2'b10;

    // Reported in the low half of the ID register
    localparam logic [15:0] MODULE_VERSION = 16'd1;

endpackage

//--- design/symb_rate_pkg.sv
/* Symbol rate datapath types */
package symb_rate_pkg;

    // Width of the rate selection field
    localparam int SYMB_RATE_SEL_W = 2;

    // One complex sample, I in the upper half-word
    typedef struct packed {
        logic signed [15:0] i;
        logic signed [15:0] q;
    } iq_sample_t;

    // Rate selection codes
    // Code 3 is not named and behaves as full rate
    typedef enum logic [SYMB_RATE_SEL_W-1:0] {
        RATE_FULL    = 2'd0,
        RATE_HALF    = 2'd1,
        RATE_QUARTER = 2'd2
    } symb_rate_sel_e;

    // Output samples per input symbol for a selection
    function automatic logic [2:0] rate_divisor(
        input logic [SYMB_RATE_SEL_W-1:0] sel
    );
        case (sel)
            RATE_HALF: begin
                return 3'd2;
            end
            RATE_QUARTER: begin
                return 3'd4;
            end
            default: begin
                return 3'd1;
            end
        endcase
    endfunction

endpackage
